/* files.f */
+incdir+.
vec_pkg.sv
vec_ctrl_if.sv
vec_decode.sv
vec_lane.sv
vec_result.sv
vec_lane_array.sv
tb_vec_lane_array.sv

/* Bender.yml */
package:
  name: vec_lane_array

sources:
  - files:
      - vec_pkg.sv
      - vec_ctrl_if.sv
      - vec_decode.sv
      - vec_lane.sv
      - vec_result.sv
      - vec_lane_array.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_vec_lane_array.sv

/* tb_vec_checks.svh */
int check_cnt = 0;
int err_cnt   = 0;

task automatic check_elem(input string name, input vec_pkg::elem_t got,
                          input vec_pkg::elem_t exp);
    check_cnt++;
    if (got !== exp) begin
        err_cnt++;
        $display("Mismatch at %0d ns: %s got %08h expected %08h", $time, name, got, exp);
    end
endtask

task automatic check_valid(input string name, input logic got, input logic exp);
    check_cnt++;
    if (got !== exp) begin
        err_cnt++;
        $display("Mismatch at %0d ns: %s got %b expected %b", $time, name, got, exp);
    end
endtask

// Edge count from accept to ack high
task automatic check_count(input string name, input int got, input int exp);
    check_cnt++;
    if (got != exp) begin
        err_cnt++;
        $display("Mismatch at %0d ns: %s got %0d expected %0d", $time, name, got, exp);
    end
endtask

/* tb_vec_lane_array.sv */
module tb_vec_lane_array;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int VLANE      = 8;
    localparam int NREGS      = 8;
    localparam int CLK_PERIOD = 100;

    typedef struct {
        vec_pkg::opcode_t                op;
        vec_pkg::vreg_idx_t              vd;
        vec_pkg::vreg_idx_t              vs1;
        vec_pkg::vreg_idx_t              vs2;
        vec_pkg::elem_t                  scalar;
        vec_pkg::elem_t [VLANE-1:0]      load;
        vec_pkg::elem_t [VLANE-1:0]      exp;   // Only used by stores
    } row_t;

    logic                            clk      = 1'b0;
    logic                            rst_n    = 1'b0;
    logic                            req      = 1'b0;
    vec_pkg::opcode_t                opcode   = vec_pkg::OP_LOAD;
    vec_pkg::vreg_idx_t              vd       = '0;
    vec_pkg::vreg_idx_t              vs1      = '0;
    vec_pkg::vreg_idx_t              vs2      = '0;
    vec_pkg::elem_t                  scalar   = '0;
    vec_pkg::elem_t [VLANE-1:0]      load_data = '0;
    vec_pkg::elem_t [VLANE-1:0]      store_data;
    logic                            ack;
    logic                            store_valid;

    row_t            rows [$];
    vec_pkg::elem_t  model_rf [NREGS][VLANE]; // Expected register contents
    bit              table_built = 1'b0;

    `include "tb_vec_checks.svh"

    vec_lane_array #(
        .VLANE_NUM (VLANE),
        .NUM_VREGS (NREGS)
    ) dut (
        .clk_i         (clk),
        .rst_n_i       (rst_n),
        .req_i         (req),
        .ack_o         (ack),
        .opcode_i      (opcode),
        .vd_i          (vd),
        .vs1_i         (vs1),
        .vs2_i         (vs2),
        .scalar_i      (scalar),
        .load_data_i   (load_data),
        .store_data_o  (store_data),
        .store_valid_o (store_valid)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    //////////////////////////////////////////////////////////////////////
    // Stimulus table with reference model

    task automatic add_row(input vec_pkg::opcode_t op, input vec_pkg::vreg_idx_t rd,
                           input vec_pkg::vreg_idx_t rs1, input vec_pkg::vreg_idx_t rs2,
                           input vec_pkg::elem_t sc);
        row_t            r;
        vec_pkg::elem_t  res [VLANE];
        vec_pkg::elem_t  sum;
        vec_pkg::elem_t  a;
        r.op     = op;
        r.vd     = rd;
        r.vs1    = rs1;
        r.vs2    = rs2;
        r.scalar = sc;
        r.exp    = '0;
        sum      = '0;
        for (int i = 0; i < VLANE; i++) begin
            r.load[i] = $urandom();
            sum      += model_rf[rs1][i]; // 32-bit wrap
            res[i]    = model_rf[rd][i];
        end
        for (int i = 0; i < VLANE; i++) begin
            a = model_rf[rs1][i];
            case (op)
                vec_pkg::OP_LOAD:       res[i] = r.load[i];
                vec_pkg::OP_STORE:      r.exp[i] = a;
                vec_pkg::OP_ADD_VX:     res[i] = a + sc;
                vec_pkg::OP_SUB_VX:     res[i] = a - sc;
                vec_pkg::OP_AND_VX:     res[i] = a & sc;
                vec_pkg::OP_OR_VX:      res[i] = a | sc;
                vec_pkg::OP_XOR_VX:     res[i] = a ^ sc;
                vec_pkg::OP_ADD_VV:     res[i] = a + model_rf[rs2][i];
                vec_pkg::OP_SLIDE_UP:   res[i] = model_rf[rs1][(i + VLANE - 1) % VLANE];
                vec_pkg::OP_SLIDE_DOWN: res[i] = model_rf[rs1][(i + 1) % VLANE];
                vec_pkg::OP_REDSUM:     if (i == 0) res[i] = sum; // Rest of vd kept
                default:                res[i] = res[i];
            endcase
        end
        if (op != vec_pkg::OP_STORE) begin
            for (int i = 0; i < VLANE; i++) begin
                model_rf[rd][i] = res[i];
            end
        end
        rows.push_back(r);
    endtask

    task automatic build_table();
        for (int r = 0; r < NREGS; r++) begin
            for (int i = 0; i < VLANE; i++) begin
                model_rf[r][i] = '0;
            end
        end
        add_row(vec_pkg::OP_LOAD,       3'd1, 3'd0, 3'd0, $urandom());
        add_row(vec_pkg::OP_LOAD,       3'd2, 3'd0, 3'd0, $urandom());
        add_row(vec_pkg::OP_STORE,      3'd0, 3'd1, 3'd0, $urandom());
        add_row(vec_pkg::OP_STORE,      3'd0, 3'd2, 3'd0, $urandom());
        add_row(vec_pkg::OP_ADD_VX,     3'd3, 3'd1, 3'd0, $urandom());
        add_row(vec_pkg::OP_STORE,      3'd0, 3'd3, 3'd0, $urandom());
        add_row(vec_pkg::OP_SUB_VX,     3'd4, 3'd1, 3'd0, $urandom());
        add_row(vec_pkg::OP_STORE,      3'd0, 3'd4, 3'd0, $urandom());
        add_row(vec_pkg::OP_AND_VX,     3'd5, 3'd2, 3'd0, $urandom());
        add_row(vec_pkg::OP_STORE,      3'd0, 3'd5, 3'd0, $urandom());
        add_row(vec_pkg::OP_OR_VX,      3'd6, 3'd1, 3'd0, $urandom());
        add_row(vec_pkg::OP_STORE,      3'd0, 3'd6, 3'd0, $urandom());
        add_row(vec_pkg::OP_XOR_VX,     3'd7, 3'd2, 3'd0, $urandom());
        add_row(vec_pkg::OP_STORE,      3'd0, 3'd7, 3'd0, $urandom());
        add_row(vec_pkg::OP_ADD_VV,     3'd3, 3'd1, 3'd2, $urandom());
        add_row(vec_pkg::OP_STORE,      3'd0, 3'd3, 3'd0, $urandom());
        add_row(vec_pkg::OP_SLIDE_DOWN, 3'd4, 3'd1, 3'd0, $urandom());
        add_row(vec_pkg::OP_STORE,      3'd0, 3'd4, 3'd0, $urandom());
        add_row(vec_pkg::OP_SLIDE_UP,   3'd5, 3'd2, 3'd0, $urandom());
        add_row(vec_pkg::OP_STORE,      3'd0, 3'd5, 3'd0, $urandom());
        add_row(vec_pkg::OP_REDSUM,     3'd6, 3'd1, 3'd0, $urandom());
        add_row(vec_pkg::OP_STORE,      3'd0, 3'd6, 3'd0, $urandom());
    endtask

    //////////////////////////////////////////////////////////////////////
    // Four-phase handshake for one row

    task automatic send_instr(input int idx);
        int  edges;
        bit  seen;
        @(posedge clk);
        opcode    <= rows[idx].op;
        vd        <= rows[idx].vd;
        vs1       <= rows[idx].vs1;
        vs2       <= rows[idx].vs2;
        scalar    <= rows[idx].scalar;
        load_data <= rows[idx].load;
        req       <= 1'b1;
        edges = 0;
        seen  = 1'b0;
        while (!seen && edges < 4 * vec_pkg::EXEC_LATENCY) begin
            @(posedge clk);
            edges++;           // First edge here is the accept edge
            @(negedge clk);
            seen = ack;
        end
        if (!seen) begin
            err_cnt++;
            $display("Error at %0d ns: ack_o did not rise within %0d edges of the request",
                     $time, edges);
        end else begin
            check_count("ack_o latency", edges, vec_pkg::EXEC_LATENCY);
            check_valid("store_valid_o", store_valid, rows[idx].op == vec_pkg::OP_STORE);
            if (rows[idx].op == vec_pkg::OP_STORE) begin
                for (int i = 0; i < VLANE; i++) begin
                    check_elem($sformatf("store_data_o[%0d]", i), store_data[i],
                               rows[idx].exp[i]);
                end
            end
        end
        @(posedge clk);
        req <= 1'b0;
        @(negedge clk);
        check_valid("ack_o", ack, 1'b1); // Still high until req low is sampled
        @(negedge clk);
        check_valid("ack_o", ack, 1'b0);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Main sequence

    initial begin
        int                errs_before;
        int                failed_tests;
        vec_pkg::opcode_t  op;
        failed_tests = 0;
        void'($urandom(75810));
        build_table();
        table_built = 1'b1;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        errs_before = err_cnt;
        check_valid("ack_o", ack, 1'b0);
        check_valid("store_valid_o", store_valid, 1'b0);
        if (err_cnt != errs_before) failed_tests++;
        $display("Test  - %-13s %s", "reset", (err_cnt == errs_before) ? "ok" : "FAIL");
        for (int t = 0; t < rows.size(); t++) begin
            errs_before = err_cnt;
            op          = rows[t].op;
            send_instr(t);
            if (err_cnt != errs_before) failed_tests++;
            $display("Test %2d %-13s %s", t, op.name(), (err_cnt == errs_before) ? "ok" : "FAIL");
        end
        $display("Tests: %0d, failed: %0d, checks: %0d, errors: %0d",
                 rows.size() + 1, failed_tests, check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    // Watchdog
    initial begin
        wait (table_built);
        #(2 * rows.size() * 10 * CLK_PERIOD);
        $display("Timeout at %0d ns: a handshake never finished", $time);
        $display("Result: FAILED");
        $finish;
    end

endmodule

/* vec_lane_array.sv */
module vec_lane_array #(
    parameter int VLANE_NUM = 8,
    parameter int NUM_VREGS = 8
) (
    input  logic                            clk_i,
    input  logic                            rst_n_i,

    // Instruction handshake
    input  logic                            req_i,
    output logic                            ack_o,
    input  vec_pkg::opcode_t                opcode_i,
    input  vec_pkg::vreg_idx_t              vd_i,
    input  vec_pkg::vreg_idx_t              vs1_i,
    input  vec_pkg::vreg_idx_t              vs2_i,
    input  vec_pkg::elem_t                  scalar_i,

    // Per-lane load and store
    input  vec_pkg::elem_t [VLANE_NUM-1:0]  load_data_i,
    output vec_pkg::elem_t [VLANE_NUM-1:0]  store_data_o,
    output logic                            store_valid_o
);

    vec_ctrl_if ctrl_if (.clk_i(clk_i));

    vec_pkg::elem_t [VLANE_NUM-1:0]  operand;
    vec_pkg::elem_t [VLANE_NUM-1:0]  net_elem;

    vec_decode u_decode (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .req_i         (req_i),
        .ack_o         (ack_o),
        .opcode_i      (opcode_i),
        .vd_i          (vd_i),
        .vs1_i         (vs1_i),
        .vs2_i         (vs2_i),
        .scalar_i      (scalar_i),
        .store_valid_o (store_valid_o),
        .ctrl          (ctrl_if)
    );

    //////////////////////////////////////////////////////////////////////
    // Lanes

    for (genvar i = 0; i < VLANE_NUM; i++) begin : g_lane
        vec_lane #(
            .VLANE_NUM (VLANE_NUM),
            .NUM_VREGS (NUM_VREGS),
            .LANE_ID   (i)
        ) u_lane (
            .clk_i        (clk_i),
            .rst_n_i      (rst_n_i),
            .ctrl         (ctrl_if),
            .load_elem_i  (load_data_i[i]),
            .net_elem_i   (net_elem[i]),
            .operand_o    (operand[i]),
            .store_elem_o (store_data_o[i])
        );
    end

    // Cross-lane slide and sum
    vec_result #(
        .VLANE_NUM (VLANE_NUM)
    ) u_result (
        .ctrl      (ctrl_if),
        .operand_i (operand),
        .net_o     (net_elem)
    );

endmodule

/* vec_result.sv */
module vec_result #(
    parameter int VLANE_NUM = 8
) (
    vec_ctrl_if.net                         ctrl,
    input  vec_pkg::elem_t [VLANE_NUM-1:0]  operand_i,
    output vec_pkg::elem_t [VLANE_NUM-1:0]  net_o
);

    vec_pkg::elem_t [VLANE_NUM-1:0]  ring;
    vec_pkg::elem_t                  sum;

    //////////////////////////////////////////////////////////////////////
    // Slide ring, one lane with wrap

    always_comb begin
        if (ctrl.slide_up) begin
            // Lane i takes lane i-1
            ring[0] = operand_i[VLANE_NUM-1];
            for (int i = 1; i < VLANE_NUM; i++) begin
                ring[i] = operand_i[i-1];
            end
        end else begin
            // Lane i takes lane i+1
            for (int i = 0; i < VLANE_NUM - 1; i++) begin
                ring[i] = operand_i[i+1];
            end
            ring[VLANE_NUM-1] = operand_i[0];
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Reduction

    always_comb begin
        sum = operand_i[0];
        for (int i = 1; i < VLANE_NUM; i++) begin
            sum = sum + operand_i[i]; // Wraps at 32 bits
        end
    end

    always_comb begin
        net_o = ring;
        if (ctrl.wen_lane0_only) begin
            net_o[0] = sum;
        end
    end

    a_lane0_takes_net: assert property (
        @(posedge ctrl.clk_i)
        (ctrl.commit && ctrl.wen_lane0_only) |-> (ctrl.wb_src == vec_pkg::WB_NET)
    ) else $error("reduction write-back not sourced from the result network");

endmodule

/* vec_lane.sv */
module vec_lane #(
    parameter int VLANE_NUM = 8,
    parameter int NUM_VREGS = 8,
    parameter int LANE_ID   = 0
) (
    input  logic            clk_i,
    input  logic            rst_n_i,
    vec_ctrl_if.lane        ctrl,
    input  vec_pkg::elem_t  load_elem_i,
    input  vec_pkg::elem_t  net_elem_i,   // From slide ring or reduction
    output vec_pkg::elem_t  operand_o,
    output vec_pkg::elem_t  store_elem_o
);

    if (LANE_ID < 0 || LANE_ID >= VLANE_NUM) begin : g_bad_lane_id
        $error("vec_lane: LANE_ID %0d outside 0..%0d", LANE_ID, VLANE_NUM - 1);
    end

    vec_pkg::elem_t  vregs [NUM_VREGS];   // This lane's slice of each register
    vec_pkg::elem_t  op_a_q;
    vec_pkg::elem_t  op_b_q;
    vec_pkg::elem_t  alu_res;
    vec_pkg::elem_t  wb_data;
    logic            we;

    //////////////////////////////////////////////////////////////////////
    // Operand read

    always_ff @(posedge clk_i) begin
        if (ctrl.issue) begin
            op_a_q <= vregs[ctrl.vs1];
            op_b_q <= ctrl.opb_vec ? vregs[ctrl.vs2] : ctrl.scalar;
        end
    end

    assign operand_o = op_a_q;

    always_comb begin
        case (ctrl.alu_op)
            vec_pkg::ALU_ADD: alu_res = op_a_q + op_b_q;
            vec_pkg::ALU_SUB: alu_res = op_a_q - op_b_q;
            vec_pkg::ALU_AND: alu_res = op_a_q & op_b_q;
            vec_pkg::ALU_OR:  alu_res = op_a_q | op_b_q;
            vec_pkg::ALU_XOR: alu_res = op_a_q ^ op_b_q;
            default:          alu_res = op_a_q;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // Write-back and store

    always_comb begin
        case (ctrl.wb_src)
            vec_pkg::WB_NET:  wb_data = net_elem_i;
            vec_pkg::WB_LOAD: wb_data = load_elem_i;
            default:          wb_data = alu_res;
        endcase
    end

    assign we = ctrl.commit && ctrl.wen && (!ctrl.wen_lane0_only || LANE_ID == 0);

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int r = 0; r < NUM_VREGS; r++) begin
                vregs[r] <= '0;
            end
        end else if (we) begin
            vregs[ctrl.vd] <= wb_data;
        end
    end

    // Store data stays put until the next store
    always_ff @(posedge clk_i) begin
        if (ctrl.commit && ctrl.store_en) begin
            store_elem_o <= op_a_q;
        end
    end

    a_store_no_write: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        (ctrl.commit && ctrl.store_en) |-> !ctrl.wen
    ) else $error("lane %0d: store commit with write enable", LANE_ID);

endmodule

/* vec_decode.sv */
module vec_decode (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic                req_i,
    output logic                ack_o,
    input  vec_pkg::opcode_t    opcode_i,
    input  vec_pkg::vreg_idx_t  vd_i,
    input  vec_pkg::vreg_idx_t  vs1_i,
    input  vec_pkg::vreg_idx_t  vs2_i,
    input  vec_pkg::elem_t      scalar_i,
    output logic                store_valid_o,
    vec_ctrl_if.dec             ctrl
);

    typedef enum logic [1:0] {
        IDLE,
        READ,
        COMMIT,
        ACK
    } state_t;

    state_t            state_q;
    logic              accept;
    vec_pkg::alu_op_t  alu_op_d;
    vec_pkg::wb_src_t  wb_src_d;
    logic              wen_d;
    logic              lane0_d;
    logic              store_d;
    logic              slide_up_d;
    logic              opb_vec_d;

    assign accept = (state_q == IDLE) && req_i; // ack_o is low in IDLE

    //////////////////////////////////////////////////////////////////////
    // Opcode decode

    always_comb begin
        alu_op_d   = vec_pkg::ALU_ADD;
        wb_src_d   = vec_pkg::WB_ALU;
        wen_d      = 1'b1;
        lane0_d    = 1'b0;
        store_d    = 1'b0;
        slide_up_d = 1'b0;
        opb_vec_d  = 1'b0;
        case (opcode_i)
            vec_pkg::OP_LOAD:       wb_src_d = vec_pkg::WB_LOAD;
            vec_pkg::OP_STORE: begin
                wen_d   = 1'b0;
                store_d = 1'b1;
            end
            vec_pkg::OP_ADD_VX:     alu_op_d = vec_pkg::ALU_ADD;
            vec_pkg::OP_SUB_VX:     alu_op_d = vec_pkg::ALU_SUB;
            vec_pkg::OP_AND_VX:     alu_op_d = vec_pkg::ALU_AND;
            vec_pkg::OP_OR_VX:      alu_op_d = vec_pkg::ALU_OR;
            vec_pkg::OP_XOR_VX:     alu_op_d = vec_pkg::ALU_XOR;
            vec_pkg::OP_ADD_VV:     opb_vec_d = 1'b1;
            vec_pkg::OP_SLIDE_UP: begin
                wb_src_d   = vec_pkg::WB_NET;
                slide_up_d = 1'b1;
            end
            vec_pkg::OP_SLIDE_DOWN: wb_src_d = vec_pkg::WB_NET;
            vec_pkg::OP_REDSUM: begin
                wb_src_d = vec_pkg::WB_NET;
                lane0_d  = 1'b1;
            end
            default:                wen_d = 1'b0; // Unknown opcode, handshake only
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // Handshake FSM

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= IDLE;
        end else begin
            case (state_q)
                IDLE:    if (req_i) state_q <= READ;
                READ:    state_q <= COMMIT;
                COMMIT:  state_q <= ACK;
                ACK:     if (!req_i) state_q <= IDLE;
                default: state_q <= IDLE;
            endcase
        end
    end

    assign ctrl.issue  = (state_q == READ);
    assign ctrl.commit = (state_q == COMMIT);
    assign ack_o       = (state_q == ACK);

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ctrl.alu_op         <= vec_pkg::ALU_ADD;
            ctrl.wb_src         <= vec_pkg::WB_ALU;
            ctrl.wen            <= 1'b0;
            ctrl.wen_lane0_only <= 1'b0;
            ctrl.store_en       <= 1'b0;
            ctrl.slide_up       <= 1'b0;
            ctrl.opb_vec        <= 1'b0;
            store_valid_o       <= 1'b0;
        end else begin
            if (accept) begin
                ctrl.alu_op         <= alu_op_d;
                ctrl.wb_src         <= wb_src_d;
                ctrl.wen            <= wen_d;
                ctrl.wen_lane0_only <= lane0_d;
                ctrl.store_en       <= store_d;
                ctrl.slide_up       <= slide_up_d;
                ctrl.opb_vec        <= opb_vec_d;
                store_valid_o       <= 1'b0;
            end else if (ctrl.commit && ctrl.store_en) begin
                store_valid_o <= 1'b1; // Held until the next request
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            ctrl.vd     <= vd_i;
            ctrl.vs1    <= vs1_i;
            ctrl.vs2    <= vs2_i;
            ctrl.scalar <= scalar_i;
        end
    end

    a_ack_needs_req: assert property (
        @(posedge clk_i) disable iff (!rst_n_i) $rose(ack_o) |-> req_i
    ) else $error("ack_o rose without a pending request");

    // Lanes read at issue, write at commit, ack lands on the write edge
    a_issue_to_ack: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        ctrl.issue |-> ##(vec_pkg::EXEC_LATENCY - 2) ctrl.commit ##1 ack_o
    ) else $error("commit not followed by ack_o");

endmodule

/* vec_ctrl_if.sv */
interface vec_ctrl_if (
    input logic clk_i
);

    logic                issue;          // Operand read cycle
    logic                commit;         // Write-back cycle
    vec_pkg::alu_op_t    alu_op;
    vec_pkg::wb_src_t    wb_src;
    logic                wen;
    logic                wen_lane0_only; // Reduction result goes to element 0
    logic                store_en;
    logic                slide_up;
    logic                opb_vec;        // ALU operand b from vs2 instead of scalar
    vec_pkg::vreg_idx_t  vd;
    vec_pkg::vreg_idx_t  vs1;
    vec_pkg::vreg_idx_t  vs2;
    vec_pkg::elem_t      scalar;

    modport dec (
        output issue, commit, alu_op, wb_src, wen, wen_lane0_only, store_en,
        output slide_up, opb_vec, vd, vs1, vs2, scalar
    );

    modport lane (
        input issue, commit, alu_op, wb_src, wen, wen_lane0_only, store_en,
        input opb_vec, vd, vs1, vs2, scalar
    );

    modport net (input clk_i, commit, wb_src, wen_lane0_only, slide_up);

endinterface

/* vec_pkg.sv */
package vec_pkg;

    //////////////////////////////////////////////////////////////////////
    // Data widths

    typedef logic [31:0] elem_t;     // One element per lane
    typedef logic [2:0]  vreg_idx_t; // Eight vector registers

    //////////////////////////////////////////////////////////////////////
    // Instruction set

    typedef enum logic [3:0] {
        OP_LOAD,
        OP_STORE,
        OP_ADD_VX,
        OP_SUB_VX,
        OP_AND_VX,
        OP_OR_VX,
        OP_XOR_VX,
        OP_ADD_VV,
        OP_SLIDE_UP,
        OP_SLIDE_DOWN,
        OP_REDSUM
    } opcode_t;

    // Write-back source in the lane
    typedef enum logic [1:0] {
        WB_ALU,
        WB_NET,  // Slide ring or reduction sum
        WB_LOAD
    } wb_src_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR
    } alu_op_t;

    // Rising edges from accept to ack high, accept edge counted as the first
    localparam int EXEC_LATENCY = 3;

endpackage
